// File: compile.f
issue_pkg.sv
issue_bank_ram.sv
issue_enqueue.sv
issue_queue.sv
issue_pair_select.sv
issue_stage.sv
tb_issue_stage.sv

// File: Bender.yml
package:
  name: issue_stage

sources:
  - issue_pkg.sv
  - issue_bank_ram.sv
  - issue_enqueue.sv
  - issue_queue.sv
  - issue_pair_select.sv
  - issue_stage.sv
  - target: simulation
    files:
      - tb_issue_stage.sv

// File: tb_issue_stage.sv
`timescale 1ns/1ps

module tb_issue_stage;

    localparam int CLK_PERIOD = 100;
    // about four times the cycles the six tests need
    localparam int WATCHDOG_CYCLES = 400;
    localparam logic [31:0] OP_BASE = 32'h0040_0000;
    // live ops alternate banks so one bank holds 15 once 29 ops are stored
    localparam int MODEL_FULL = 2 * (issue_pkg::BANK_DEPTH - 1) - 1;

    logic                                 clk;
    logic                                 rst_n;
    logic                                 flush;
    logic                                 stall;
    logic [1:0]                           dec_valid;
    logic [1:0][issue_pkg::ADDR_BITS-1:0] dec_pc;
    logic [1:0][issue_pkg::REG_BITS-1:0]  dec_rdst;
    logic [1:0][issue_pkg::REG_BITS-1:0]  dec_ra1;
    logic [1:0][issue_pkg::REG_BITS-1:0]  dec_ra2;
    logic [1:0]                           dec_regwrite;
    logic [1:0]                           dec_branch;
    logic [1:0]                           dec_muldiv;
    logic [1:0]                           dec_hi_write;
    logic [1:0]                           dec_lo_write;
    logic [1:0]                           dec_hi_read;
    logic [1:0]                           dec_lo_read;
    logic [1:0]                           dec_single_issue;
    logic [1:0]                           src_ready;
    logic                                 full;
    logic [1:0][issue_pkg::REG_BITS-1:0]  cand_ra1;
    logic [1:0][issue_pkg::REG_BITS-1:0]  cand_ra2;
    logic [1:0]                           iss_valid;
    logic [1:0][issue_pkg::ADDR_BITS-1:0] iss_pc;
    logic [1:0][issue_pkg::REG_BITS-1:0]  iss_rdst;
    logic                                 iss_is_slot;

    // reference model as a program-order queue of stored ops
    issue_pkg::op_t mq [$];
    issue_pkg::op_t drv [2];
    logic [1:0]     exp_take;
    int             cyc;
    int             next_k;
    // what the DUT issued per pc word
    int             iss_at [256];
    logic           slot_at [256];
    int             n_issued;
    string          cur_test;
    int             errors;
    int             test_errors;
    int             tests_run;
    int             tests_failed;

    issue_stage UUT (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic compare(string what, logic [63:0] exp, logic [63:0] act);
        if (exp !== act) begin
            errors++;
            $display("FAIL %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
        end
    endtask

    // pairing rules on the two oldest entries with lane 0 older
    function automatic logic [1:0] pair_rule(issue_pkg::op_t a, issue_pkg::op_t b,
                                             logic [1:0] rdy);
        logic go_a;
        logic go_b;
        logic split;
        go_b = b.valid && rdy[1];
        // a branch only leaves together with its delay slot
        go_a = a.valid && rdy[0] && (!a.branch || go_b);
        split = b.branch || a.single_issue || b.single_issue || (a.muldiv && b.muldiv);
        split = split || (a.hi_write && b.hi_read) || (a.lo_write && b.lo_read);
        // the delay slot still reads the value from before the branch
        if (!a.branch && a.regwrite && (a.rdst == b.ra1 || a.rdst == b.ra2)) begin
            split = 1'b1;
        end
        return {go_a && go_b && !split, go_a};
    endfunction

    function automatic issue_pkg::op_t next_op();
        issue_pkg::op_t o;
        o = '0;
        o.valid = 1'b1;
        o.pc = OP_BASE + 32'(next_k * 4);
        // destinations 16..31 and sources 0..15 keep filler free of hazards
        o.rdst = 5'(16 + $urandom % 16);
        o.ra1 = 5'($urandom % 16);
        o.ra2 = 5'($urandom % 16);
        o.regwrite = 1'($urandom % 2);
        next_k++;
        return o;
    endfunction

    function automatic int issue_cycle(issue_pkg::op_t o);
        return iss_at[o.pc[9:2]];
    endfunction

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic drive(issue_pkg::op_t a, issue_pkg::op_t b);
        drv[0] = a;
        drv[1] = b;
        for (int s = 0; s < 2; s++) begin
            dec_valid[s]        = drv[s].valid;
            dec_pc[s]           = drv[s].pc;
            dec_rdst[s]         = drv[s].rdst;
            dec_ra1[s]          = drv[s].ra1;
            dec_ra2[s]          = drv[s].ra2;
            dec_regwrite[s]     = drv[s].regwrite;
            dec_branch[s]       = drv[s].branch;
            dec_muldiv[s]       = drv[s].muldiv;
            dec_hi_write[s]     = drv[s].hi_write;
            dec_lo_write[s]     = drv[s].lo_write;
            dec_hi_read[s]      = drv[s].hi_read;
            dec_lo_read[s]      = drv[s].lo_read;
            dec_single_issue[s] = drv[s].single_issue;
        end
    endtask

    // hold the pair until an edge with stall and full low takes it
    task automatic push(issue_pkg::op_t a, issue_pkg::op_t b);
        logic taken;
        drive(a, b);
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = !stall && !full;
            tick();
        end
        drive('0, '0);
    endtask

    task automatic drain();
        src_ready = 2'b11;
        while (mq.size() != 0) begin
            tick();
        end
        tick();
    endtask

    task automatic start_test(string name);
        cur_test = name;
        test_errors = errors;
    endtask

    task automatic report_test();
        tests_run++;
        if (errors == test_errors) begin
            $display("test %-16s passed", cur_test);
        end else begin
            tests_failed++;
            $display("test %-16s failed, %0d errors", cur_test, errors - test_errors);
        end
    endtask

    // pair stored first and released later so the younger must trail
    task automatic check_split(string what, issue_pkg::op_t a, issue_pkg::op_t b);
        src_ready = 2'b00;
        push(a, b);
        drain();
        compare(what, 1, issue_cycle(b) > issue_cycle(a));
    endtask

    // mid-cycle compare where inputs and outputs are settled
    always @(negedge clk) begin : check_outputs
        issue_pkg::op_t c0;
        issue_pkg::op_t c1;
        if (rst_n) begin
            c0 = (mq.size() > 0) ? mq[0] : '0;
            c1 = (mq.size() > 1) ? mq[1] : '0;
            exp_take = pair_rule(c0, c1, src_ready);
            compare("iss_valid", exp_take, iss_valid);
            compare("iss_pc", {exp_take[1] ? c1.pc : 32'h0, exp_take[0] ? c0.pc : 32'h0},
                    iss_pc);
            compare("iss_rdst", {exp_take[1] ? c1.rdst : 5'h0, exp_take[0] ? c0.rdst : 5'h0},
                    iss_rdst);
            compare("iss_is_slot", exp_take[1] & c0.branch, iss_is_slot);
            compare("cand_ra1", {c1.ra1, c0.ra1}, cand_ra1);
            compare("cand_ra2", {c1.ra2, c0.ra2}, cand_ra2);
            compare("full", mq.size() >= MODEL_FULL, full);
            // log only what the coming edge consumes
            if (!stall && !flush) begin
                for (int i = 0; i < 2; i++) begin
                    if (iss_valid[i]) begin
                        iss_at[iss_pc[i][9:2]] = cyc;
                        slot_at[iss_pc[i][9:2]] = (i == 1) && iss_is_slot;
                        n_issued++;
                    end
                end
            end
        end
    end

    // model step at each edge from driven inputs and model state
    always @(posedge clk or negedge rst_n) begin : model_update
        logic accept;
        if (!rst_n) begin
            mq.delete();
            cyc = 0;
        end else begin
            cyc++;
            if (flush) begin
                mq.delete();
            end else if (!stall) begin
                // full is judged before this edge's pops
                accept = mq.size() < MODEL_FULL;
                if (exp_take[0]) begin
                    void'(mq.pop_front());
                end
                if (exp_take[1]) begin
                    void'(mq.pop_front());
                end
                for (int s = 0; s < 2; s++) begin
                    if (accept && drv[s].valid) begin
                        mq.push_back(drv[s]);
                    end
                end
            end
        end
    end

    task automatic reset_and_flush();
        start_test("reset");
        @(negedge clk);
        compare("iss_valid after reset", 0, iss_valid);
        compare("full after reset", 0, full);
        tick();
        push(next_op(), next_op());
        push(next_op(), next_op());
        flush = 1'b1;
        tick();
        flush = 1'b0;
        src_ready = 2'b11;
        @(negedge clk);
        compare("iss_valid after flush", 0, iss_valid);
        tick();
        report_test();
    endtask

    task automatic order_and_pairing();
        issue_pkg::op_t a;
        issue_pkg::op_t b;
        int first;
        int start;
        start_test("order");
        src_ready = 2'b11;
        first = next_k;
        start = cyc + 1;
        for (int p = 0; p < 3; p++) begin
            push(next_op(), next_op());
        end
        drain();
        // each pair issues in the cycle after its own acceptance
        for (int p = 0; p < 3; p++) begin
            compare("pair cycle", iss_at[first + 2 * p], iss_at[first + 2 * p + 1]);
            compare("pair spacing", start + p, iss_at[first + 2 * p]);
        end
        src_ready = 2'b00;
        a = next_op();
        b = next_op();
        push(a, b);
        @(negedge clk);
        compare("iss_valid not ready", 0, iss_valid);
        compare("oldest ra1", {b.ra1, a.ra1}, cand_ra1);
        compare("oldest ra2", {b.ra2, a.ra2}, cand_ra2);
        tick();
        drain();
        report_test();
    endtask

    task automatic dependency_split();
        issue_pkg::op_t a;
        issue_pkg::op_t b;
        start_test("dependency");
        a = next_op();
        b = next_op();
        a.regwrite = 1'b1;
        b.ra2 = a.rdst;
        check_split("raw producer first", a, b);
        report_test();
    endtask

    task automatic branch_delay_slot();
        issue_pkg::op_t br;
        issue_pkg::op_t slot;
        issue_pkg::op_t c;
        issue_pkg::op_t d;
        issue_pkg::op_t e;
        int base;
        start_test("branch");
        br = next_op();
        br.branch = 1'b1;
        br.regwrite = 1'b1;
        // slot reads the link register and still pairs
        slot = next_op();
        slot.ra1 = br.rdst;
        src_ready = 2'b00;
        push(br, slot);
        src_ready = 2'b01;
        base = n_issued;
        tick();
        tick();
        compare("branch without slot", base, n_issued);
        drain();
        compare("slot with branch", issue_cycle(br), issue_cycle(slot));
        compare("slot marked", 1, slot_at[slot.pc[9:2]]);
        // branch arrives as the younger of a pair
        c = next_op();
        d = next_op();
        d.branch = 1'b1;
        e = next_op();
        src_ready = 2'b00;
        push(c, d);
        push(e, next_op());
        drain();
        compare("younger branch held", 1, issue_cycle(d) > issue_cycle(c));
        compare("late slot with branch", issue_cycle(d), issue_cycle(e));
        compare("late slot marked", 1, slot_at[e.pc[9:2]]);
        report_test();
    endtask

    task automatic resource_splits();
        issue_pkg::op_t a;
        issue_pkg::op_t b;
        start_test("resources");
        a = next_op();
        b = next_op();
        a.muldiv = 1'b1;
        b.muldiv = 1'b1;
        check_split("muldiv pair", a, b);
        a = next_op();
        b = next_op();
        a.hi_write = 1'b1;
        b.hi_read = 1'b1;
        check_split("hi write then read", a, b);
        a = next_op();
        b = next_op();
        a.single_issue = 1'b1;
        check_split("single issue older", a, b);
        a = next_op();
        b = next_op();
        b.single_issue = 1'b1;
        check_split("single issue younger", a, b);
        report_test();
    endtask

    task automatic back_pressure();
        int pairs;
        int base;
        start_test("back_pressure");
        src_ready = 2'b00;
        base = n_issued;
        pairs = 0;
        while (!full && pairs < 20) begin
            push(next_op(), next_op());
            pairs++;
        end
        compare("pairs until full", 15, pairs);
        // held pair while full and then also under stall with ready sources
        drive(next_op(), next_op());
        repeat (3) tick();
        stall = 1'b1;
        src_ready = 2'b11;
        repeat (3) tick();
        compare("issued under stall", base, n_issued);
        drive('0, '0);
        stall = 1'b0;
        drain();
        compare("ops after drain", 30, n_issued - base);
        // stall alone keeps an empty queue from taking a pair
        stall = 1'b1;
        drive(next_op(), next_op());
        repeat (3) tick();
        drive('0, '0);
        stall = 1'b0;
        tick();
        compare("taken under stall", 30, n_issued - base);
        report_test();
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        flush = 1'b0;
        stall = 1'b0;
        src_ready = 2'b00;
        exp_take = 2'b00;
        drive('0, '0);
        void'($urandom(32'h1a3c_bf37));
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        reset_and_flush();
        order_and_pairing();
        dependency_split();
        branch_delay_slot();
        resource_splits();
        back_pressure();
        $display("tests %0d run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: issue_stage.sv
`timescale 1ns/1ps

module issue_stage (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 flush,
    input  logic                                 stall,
    input  logic [1:0]                           dec_valid,
    input  logic [1:0][issue_pkg::ADDR_BITS-1:0] dec_pc,
    input  logic [1:0][issue_pkg::REG_BITS-1:0]  dec_rdst,
    input  logic [1:0][issue_pkg::REG_BITS-1:0]  dec_ra1,
    input  logic [1:0][issue_pkg::REG_BITS-1:0]  dec_ra2,
    input  logic [1:0]                           dec_regwrite,
    input  logic [1:0]                           dec_branch,
    input  logic [1:0]                           dec_muldiv,
    input  logic [1:0]                           dec_hi_write,
    input  logic [1:0]                           dec_lo_write,
    input  logic [1:0]                           dec_hi_read,
    input  logic [1:0]                           dec_lo_read,
    input  logic [1:0]                           dec_single_issue,
    input  logic [1:0]                           src_ready,
    output logic                                 full,
    output logic [1:0][issue_pkg::REG_BITS-1:0]  cand_ra1,
    output logic [1:0][issue_pkg::REG_BITS-1:0]  cand_ra2,
    output logic [1:0]                           iss_valid,
    output logic [1:0][issue_pkg::ADDR_BITS-1:0] iss_pc,
    output logic [1:0][issue_pkg::REG_BITS-1:0]  iss_rdst,
    output logic                                 iss_is_slot
);

    // enqueue to queue
    logic                           we_even;
    logic                           we_odd;
    issue_pkg::op_t                 wdata_even;
    issue_pkg::op_t                 wdata_odd;
    logic [issue_pkg::PTR_BITS-1:0] tail_even;
    logic [issue_pkg::PTR_BITS-1:0] tail_odd;
    // queue to pair select and back
    issue_pkg::op_t                 cand0;
    issue_pkg::op_t                 cand1;
    logic                           take0;
    logic                           take1;

    issue_enqueue u_enqueue (
        .clk              (clk),
        .rst_n            (rst_n),
        .flush            (flush),
        .stall            (stall),
        .full             (full),
        .dec_valid        (dec_valid),
        .dec_pc           (dec_pc),
        .dec_rdst         (dec_rdst),
        .dec_ra1          (dec_ra1),
        .dec_ra2          (dec_ra2),
        .dec_regwrite     (dec_regwrite),
        .dec_branch       (dec_branch),
        .dec_muldiv       (dec_muldiv),
        .dec_hi_write     (dec_hi_write),
        .dec_lo_write     (dec_lo_write),
        .dec_hi_read      (dec_hi_read),
        .dec_lo_read      (dec_lo_read),
        .dec_single_issue (dec_single_issue),
        .we_even          (we_even),
        .we_odd           (we_odd),
        .wdata_even       (wdata_even),
        .wdata_odd        (wdata_odd),
        .tail_even        (tail_even),
        .tail_odd         (tail_odd)
    );

    issue_queue u_queue (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (flush),
        .stall      (stall),
        .we_even    (we_even),
        .we_odd     (we_odd),
        .wdata_even (wdata_even),
        .wdata_odd  (wdata_odd),
        .tail_even  (tail_even),
        .tail_odd   (tail_odd),
        .take0      (take0),
        .take1      (take1),
        .cand0      (cand0),
        .cand1      (cand1),
        .full       (full)
    );

    issue_pair_select u_pair_select (
        .cand0       (cand0),
        .cand1       (cand1),
        .src_ready   (src_ready),
        .take0       (take0),
        .take1       (take1),
        .cand_ra1    (cand_ra1),
        .cand_ra2    (cand_ra2),
        .iss_valid   (iss_valid),
        .iss_pc      (iss_pc),
        .iss_rdst    (iss_rdst),
        .iss_is_slot (iss_is_slot)
    );

endmodule

// File: issue_pair_select.sv
`timescale 1ns/1ps

module issue_pair_select (
    input  issue_pkg::op_t                       cand0,
    input  issue_pkg::op_t                       cand1,
    input  logic [1:0]                           src_ready,
    output logic                                 take0,
    output logic                                 take1,
    output logic [1:0][issue_pkg::REG_BITS-1:0]  cand_ra1,
    output logic [1:0][issue_pkg::REG_BITS-1:0]  cand_ra2,
    output logic [1:0]                           iss_valid,
    output logic [1:0][issue_pkg::ADDR_BITS-1:0] iss_pc,
    output logic [1:0][issue_pkg::REG_BITS-1:0]  iss_rdst,
    output logic                                 iss_is_slot
);

    logic ok0;
    logic ok1;
    logic raw_hazard;
    logic muldiv_clash;
    logic hilo_clash;
    logic single_clash;
    logic pair_block;

    // sources out for the scoreboard check
    assign cand_ra1[0] = cand0.ra1;
    assign cand_ra2[0] = cand0.ra2;
    assign cand_ra1[1] = cand1.ra1;
    assign cand_ra2[1] = cand1.ra2;

    // candidate present and operands available
    assign ok0 = cand0.valid & src_ready[0];
    assign ok1 = cand1.valid & src_ready[1];

    // branch waits until its delay slot can go with it
    assign take0 = ok0 & ~(cand0.branch & ~ok1);

    // younger reads what older writes
    // a delay slot sees the old value, so no hazard behind a branch
    assign raw_hazard = cand0.regwrite & ~cand0.branch &
                        ((cand0.rdst == cand1.ra1) | (cand0.rdst == cand1.ra2));

    // single mul/div unit
    assign muldiv_clash = cand0.muldiv & cand1.muldiv;

    // hi/lo written then read in the same pair
    assign hilo_clash = (cand0.hi_write & cand1.hi_read) |
                        (cand0.lo_write & cand1.lo_read);

    assign single_clash = cand0.single_issue | cand1.single_issue;

    // branch in the younger position needs its own slot later
    assign pair_block = raw_hazard | muldiv_clash | hilo_clash | single_clash |
                        cand1.branch;

    assign take1 = take0 & ok1 & ~pair_block;

    // lane 0 older, lane 1 younger
    assign iss_valid   = {take1, take0};
    assign iss_pc[0]   = take0 ? cand0.pc : '0;
    assign iss_rdst[0] = take0 ? cand0.rdst : '0;
    assign iss_pc[1]   = take1 ? cand1.pc : '0;
    assign iss_rdst[1] = take1 ? cand1.rdst : '0;

    // younger op issued behind a branch is its delay slot
    assign iss_is_slot = take1 & cand0.branch;

endmodule

// File: issue_queue.sv
`timescale 1ns/1ps

module issue_queue (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           flush,
    input  logic                           stall,
    input  logic                           we_even,
    input  logic                           we_odd,
    input  issue_pkg::op_t                 wdata_even,
    input  issue_pkg::op_t                 wdata_odd,
    input  logic [issue_pkg::PTR_BITS-1:0] tail_even,
    input  logic [issue_pkg::PTR_BITS-1:0] tail_odd,
    input  logic                           take0,
    input  logic                           take1,
    output issue_pkg::op_t                 cand0,
    output issue_pkg::op_t                 cand1,
    output logic                           full
);

    logic [issue_pkg::PTR_BITS-1:0] head_even;
    logic [issue_pkg::PTR_BITS-1:0] head_odd;
    logic [issue_pkg::PTR_BITS-1:0] tail_even_nxt;
    logic [issue_pkg::PTR_BITS-1:0] tail_odd_nxt;
    issue_pkg::op_t                 rdata_even;
    issue_pkg::op_t                 rdata_odd;
    issue_pkg::op_t                 op_even;
    issue_pkg::op_t                 op_odd;
    logic                           odd_first;
    logic                           pop_even;
    logic                           pop_odd;

    issue_bank_ram bank_even (
        .clk   (clk),
        .we    (we_even),
        .waddr (tail_even),
        .raddr (head_even),
        .wdata (wdata_even),
        .rdata (rdata_even)
    );

    issue_bank_ram bank_odd (
        .clk   (clk),
        .we    (we_odd),
        .waddr (tail_odd),
        .raddr (head_odd),
        .wdata (wdata_odd),
        .rdata (rdata_odd)
    );

    // odd bank holds the oldest entry when heads match
    assign odd_first = (head_odd == head_even);

    // empty bank reads as a bubble
    assign op_even = (head_even != tail_even) ? rdata_even : '0;
    assign op_odd  = (head_odd != tail_odd) ? rdata_odd : '0;

    // put the two bank heads in program order
    assign cand0 = odd_first ? op_odd : op_even;
    assign cand1 = odd_first ? op_even : op_odd;

    // map older/younger takes back onto banks
    assign pop_odd  = odd_first ? take0 : take1;
    assign pop_even = odd_first ? take1 : take0;

    // one slot kept free per bank so full and empty differ
    assign tail_even_nxt = tail_even + 1'b1;
    assign tail_odd_nxt  = tail_odd + 1'b1;
    assign full = (tail_even_nxt == head_even) | (tail_odd_nxt == head_odd);

    // heads advance on issue, frozen under stall
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head_even <= '0;
            head_odd  <= '0;
        end else if (flush) begin
            head_even <= '0;
            head_odd  <= '0;
        end else if (!stall) begin
            if (pop_even) begin
                head_even <= head_even + 1'b1;
            end
            if (pop_odd) begin
                head_odd <= head_odd + 1'b1;
            end
        end
    end

endmodule

// File: issue_enqueue.sv
`timescale 1ns/1ps

module issue_enqueue (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        flush,
    input  logic                                        stall,
    input  logic                                        full,
    input  logic [1:0]                                  dec_valid,
    input  logic [1:0][issue_pkg::ADDR_BITS-1:0]        dec_pc,
    input  logic [1:0][issue_pkg::REG_BITS-1:0]         dec_rdst,
    input  logic [1:0][issue_pkg::REG_BITS-1:0]         dec_ra1,
    input  logic [1:0][issue_pkg::REG_BITS-1:0]         dec_ra2,
    input  logic [1:0]                                  dec_regwrite,
    input  logic [1:0]                                  dec_branch,
    input  logic [1:0]                                  dec_muldiv,
    input  logic [1:0]                                  dec_hi_write,
    input  logic [1:0]                                  dec_lo_write,
    input  logic [1:0]                                  dec_hi_read,
    input  logic [1:0]                                  dec_lo_read,
    input  logic [1:0]                                  dec_single_issue,
    output logic                                        we_even,
    output logic                                        we_odd,
    output issue_pkg::op_t                              wdata_even,
    output issue_pkg::op_t                              wdata_odd,
    output logic [issue_pkg::PTR_BITS-1:0]              tail_even,
    output logic [issue_pkg::PTR_BITS-1:0]              tail_odd
);

    issue_pkg::op_t dec_op [issue_pkg::ISSUE_WIDTH];
    logic           accept;
    logic           odd_gets_slot0;

    // pack each decode slot into a stored op
    always_comb begin
        for (int i = 0; i < issue_pkg::ISSUE_WIDTH; i++) begin
            dec_op[i].valid        = dec_valid[i];
            dec_op[i].pc           = dec_pc[i];
            dec_op[i].rdst         = dec_rdst[i];
            dec_op[i].ra1          = dec_ra1[i];
            dec_op[i].ra2          = dec_ra2[i];
            dec_op[i].regwrite     = dec_regwrite[i];
            dec_op[i].branch       = dec_branch[i];
            dec_op[i].muldiv       = dec_muldiv[i];
            dec_op[i].hi_write     = dec_hi_write[i];
            dec_op[i].lo_write     = dec_lo_write[i];
            dec_op[i].hi_read      = dec_hi_read[i];
            dec_op[i].lo_read      = dec_lo_read[i];
            dec_op[i].single_issue = dec_single_issue[i];
        end
    end

    // decode holds its values while this is low
    assign accept = ~stall & ~full;

    // equal tails mean odd bank is next in line
    assign odd_gets_slot0 = (tail_odd == tail_even);

    // older slot to the next bank, younger slot to the other one
    assign we_odd     = accept & (odd_gets_slot0 ? dec_valid[0] : dec_valid[1]);
    assign we_even    = accept & (odd_gets_slot0 ? dec_valid[1] : dec_valid[0]);
    assign wdata_odd  = odd_gets_slot0 ? dec_op[0] : dec_op[1];
    assign wdata_even = odd_gets_slot0 ? dec_op[1] : dec_op[0];

    // tails step once per write, wrapping at bank depth
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tail_even <= '0;
            tail_odd  <= '0;
        end else if (flush) begin
            tail_even <= '0;
            tail_odd  <= '0;
        end else begin
            if (we_even) begin
                tail_even <= tail_even + 1'b1;
            end
            if (we_odd) begin
                tail_odd <= tail_odd + 1'b1;
            end
        end
    end

endmodule

// File: issue_bank_ram.sv
`timescale 1ns/1ps

module issue_bank_ram (
    input  logic                          clk,
    input  logic                          we,
    input  logic [issue_pkg::PTR_BITS-1:0] waddr,
    input  logic [issue_pkg::PTR_BITS-1:0] raddr,
    input  issue_pkg::op_t                wdata,
    output issue_pkg::op_t                rdata
);

    // storage for one interleaved bank
    issue_pkg::op_t mem [issue_pkg::BANK_DEPTH];

    // write port, tail side
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // read port, head side, no clock
    assign rdata = mem[raddr];

endmodule

// File: issue_pkg.sv
package issue_pkg;

    // queue geometry
    localparam int BANK_DEPTH  = 16;
    localparam int PTR_BITS    = $clog2(BANK_DEPTH);
    // ops per cycle, both in and out
    localparam int ISSUE_WIDTH = 2;

    // field widths
    localparam int ADDR_BITS = 32;
    localparam int REG_BITS  = 5;

    // one stored operation, also the bank memory word
    typedef struct packed {
        logic                 valid;
        logic [ADDR_BITS-1:0] pc;
        // destination and the two source registers
        logic [REG_BITS-1:0]  rdst;
        logic [REG_BITS-1:0]  ra1;
        logic [REG_BITS-1:0]  ra2;
        logic                 regwrite;
        // set for branches and jumps alike
        logic                 branch;
        logic                 muldiv;
        // hi/lo special registers
        logic                 hi_write;
        logic                 lo_write;
        logic                 hi_read;
        logic                 lo_read;
        // must go down the pipe alone
        logic                 single_issue;
    } op_t;

endpackage
